/* src/cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

    localparam int wordSize    = 16;
    localparam int regAddrBits = 2;

    localparam logic [regAddrBits-1:0] linkReg = 2'd2;  // JAL writes the return address here
    localparam logic [wordSize-1:0] bubbleInstr = 16'hf03f;  // R-type with unused func, no-op

    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        BGZ   = 4'd2,
        BLZ   = 4'd3,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        JAL   = 4'd10,
        RTYPE = 4'd15
    } opcodeT;

    // codes 0..7 line up with aluOpT
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        NOT = 6'd4,
        TCP = 6'd5,
        SHL = 6'd6,
        SHR = 6'd7,
        JPR = 6'd25,
        WWD = 6'd28,
        HLT = 6'd29
    } funcT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluNot = 4'd4,
        aluTcp = 4'd5,
        aluShl = 4'd6,
        aluShr = 4'd7,
        aluLhi = 4'd8
    } aluOpT;

endpackage

`default_nettype wire

/* src/cpuMemPkg.sv */
`default_nettype none

package cpuMemPkg;

    localparam int memAddrBits = 8;  // 256 words, address wraps
    localparam logic [15:0] resetPc = 16'h0000;

    typedef enum logic {
        grantFetch = 1'b0,
        grantData  = 1'b1
    } grantT;

endpackage

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

module registerFile import cpuIsaPkg::*; (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  [regAddrBits-1:0] rs,
    input  wire  [regAddrBits-1:0] rt,
    input  wire  [regAddrBits-1:0] rd,
    input  wire  [wordSize-1:0]    wData,
    input  wire                    wEn,
    output logic [wordSize-1:0]    rData1,
    output logic [wordSize-1:0]    rData2
);

    logic [wordSize-1:0] regs [1 << regAddrBits];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < (1 << regAddrBits); i++) begin
                regs[i] <= '0;
            end
        end else if (wEn) begin
            regs[rd] <= wData;
        end
    end

    // WB value seen by decode in the same cycle
    assign rData1 = (wEn && rd == rs) ? wData : regs[rs];
    assign rData2 = (wEn && rd == rt) ? wData : regs[rt];

endmodule

`default_nettype wire

/* src/aluUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module aluUnit import cpuIsaPkg::*; (
    input  wire  [wordSize-1:0] a,
    input  wire  [wordSize-1:0] b,
    input  wire  aluOpT         aluOp,
    output logic [wordSize-1:0] result
);

    always_comb begin
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluNot:  result = ~a;
            aluTcp:  result = ~a + 1'b1;
            aluShl:  result = {a[wordSize-2:0], 1'b0};
            aluShr:  result = {a[wordSize-1], a[wordSize-1:1]};  // arithmetic
            aluLhi:  result = {b[7:0], 8'h00};  // immediate to upper byte
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* src/controlDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module controlDecoder import cpuIsaPkg::*; (
    input  wire  [wordSize-1:0]    instr,
    output aluOpT                  aluOp,
    output logic                   aluSrcImm,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   regWrite,
    output logic                   memToReg,
    output logic                   isWwd,
    output logic                   isHalt,
    output logic                   isBranch,
    output logic                   isJump,
    output logic                   isJumpReg,
    output logic                   useRs,
    output logic                   useRt,
    output logic [regAddrBits-1:0] destReg
);

    opcodeT opcode;
    funcT   func;

    assign opcode = opcodeT'(instr[15:12]);
    assign func   = funcT'(instr[5:0]);

    always_comb begin
        aluOp = aluAdd;
        {aluSrcImm, memRead, memWrite, regWrite, memToReg} = 5'b00000;
        {isWwd, isHalt, isBranch, isJump, isJumpReg} = 5'b00000;
        {useRs, useRt} = 2'b00;
        destReg = instr[9:8];  // rt field for immediate and load
        case (opcode)
            ADI, ORI, LHI: begin
                aluOp = (opcode == ORI) ? aluOr : ((opcode == LHI) ? aluLhi : aluAdd);
                {aluSrcImm, regWrite} = 2'b11;
                useRs = (opcode != LHI);
            end
            LWD: {aluSrcImm, memRead, regWrite, memToReg, useRs} = 5'b11111;
            SWD: {aluSrcImm, memWrite, useRs, useRt} = 4'b1111;
            BNE, BEQ, BGZ, BLZ: begin
                {isBranch, useRs} = 2'b11;
                useRt = (opcode == BNE) || (opcode == BEQ);
            end
            JMP: isJump = 1'b1;
            JAL: begin
                {isJump, regWrite} = 2'b11;
                destReg = linkReg;
            end
            RTYPE: begin
                destReg = instr[7:6];
                case (func)
                    ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR: begin
                        aluOp = aluOpT'(func[3:0]);
                        {regWrite, useRs} = 2'b11;
                        useRt = (func == ADD) || (func == SUB) || (func == AND) || (func == ORR);
                    end
                    WWD:     {isWwd, useRs} = 2'b11;
                    JPR:     {isJumpReg, useRs} = 2'b11;
                    HLT:     isHalt = 1'b1;
                    default: ;
                endcase
            end
            default: ;  // unknown opcode, nothing written
        endcase
    end

endmodule

`default_nettype wire

/* src/hazardForwardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardForwardUnit import cpuIsaPkg::*; (
    input  wire  [regAddrBits-1:0] idRs,
    input  wire  [regAddrBits-1:0] idRt,
    input  wire                    idUseRs,
    input  wire                    idUseRt,
    input  wire                    idIsBranch,
    input  wire  [regAddrBits-1:0] exRd,
    input  wire                    exRegWrite,
    input  wire                    exMemRead,
    input  wire  [regAddrBits-1:0] memRd,
    input  wire                    memRegWrite,
    input  wire  [regAddrBits-1:0] wbRd,
    input  wire                    wbRegWrite,
    input  wire  [regAddrBits-1:0] exRs,
    input  wire  [regAddrBits-1:0] exRt,
    output logic                   stall,
    output logic [1:0]             forwardA,
    output logic [1:0]             forwardB
);

    logic exHit, memHit;

    assign exHit  = (idUseRs && idRs == exRd) || (idUseRt && idRt == exRd);
    assign memHit = (idUseRs && idRs == memRd) || (idUseRt && idRt == memRd);

    // load-use, or branch/JPR operand still in flight
    assign stall = (exMemRead && exHit) ||
                   (idIsBranch && ((exRegWrite && exHit) || (memRegWrite && memHit)));

    // 10 = MEM result, 01 = WB result
    always_comb begin
        if (memRegWrite && memRd == exRs)     forwardA = 2'b10;
        else if (wbRegWrite && wbRd == exRs)  forwardA = 2'b01;
        else                                  forwardA = 2'b00;
        if (memRegWrite && memRd == exRt)     forwardB = 2'b10;
        else if (wbRegWrite && wbRd == exRt)  forwardB = 2'b01;
        else                                  forwardB = 2'b00;
    end

endmodule

`default_nettype wire

/* src/cpuDatapath.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuDatapath import cpuIsaPkg::*, cpuMemPkg::*; (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  grantT            grant,
    output logic [memAddrBits-1:0] fetchAddr,
    output logic                   fetchRead,
    input  wire  [wordSize-1:0]    fetchData,
    output logic [memAddrBits-1:0] dataAddr,
    output logic [wordSize-1:0]    dataWdata,
    output logic                   dataRead,
    output logic                   dataWrite,
    input  wire  [wordSize-1:0]    dataRdata,
    output logic [wordSize-1:0]    outputPort,
    output logic                   outputValid,
    output logic [wordSize-1:0]    numInst,
    output logic                   halted
);

    logic [wordSize-1:0] pc, pcPlus1, idInstr, idPc1;
    logic fetchOn, haltSeen, fetchOk, idValid;

    opcodeT idOp;
    aluOpT  ctlAluOp, exAluOp;
    logic ctlAluSrcImm, ctlMemRead, ctlMemWrite, ctlRegWrite, ctlMemToReg, ctlIsWwd;
    logic ctlIsHalt, ctlIsBranch, ctlIsJump, ctlIsJumpReg, ctlUseRs, ctlUseRt;
    logic [regAddrBits-1:0] idRs, idRt, ctlDest;
    logic [wordSize-1:0] idRsVal, idRtVal, idImm, branchTarget, nextPc;
    logic branchTaken, redirect, stall;

    logic exValid, exAluSrcImm, exMemRead, exMemWrite, exRegWrite, exMemToReg;
    logic exIsWwd, exIsHalt, exIsJump;
    logic [regAddrBits-1:0] exRs, exRt, exRd;
    logic [wordSize-1:0] exRsVal, exRtVal, exImm, exPc1, opA, opB, aluResult, exResult;
    logic [1:0] forwardA, forwardB;

    logic memValid, memMemRead, memMemWrite, memRegWrite, memMemToReg, memIsWwd, memIsHalt;
    logic [regAddrBits-1:0] memRd, wbRd;
    logic [wordSize-1:0] memResult, memStoreVal, wbResult, wbLoadVal, wbData;
    logic wbValid, wbRegWrite, wbMemToReg, wbIsWwd, wbIsHalt;

    assign pcPlus1   = pc + 1'b1;
    assign fetchAddr = pc[memAddrBits-1:0];
    assign fetchRead = fetchOn;
    assign fetchOk   = fetchOn && (grant == grantFetch);  // lost arbitration means a bubble

    assign idOp  = opcodeT'(idInstr[15:12]);
    assign idRs  = idInstr[11:10];
    assign idRt  = idInstr[9:8];
    assign idImm = (idOp == ORI) ? {8'h00, idInstr[7:0]} : {{8{idInstr[7]}}, idInstr[7:0]};

    controlDecoder i_decoder (
        .instr(idInstr), .aluOp(ctlAluOp), .aluSrcImm(ctlAluSrcImm), .memRead(ctlMemRead),
        .memWrite(ctlMemWrite), .regWrite(ctlRegWrite), .memToReg(ctlMemToReg),
        .isWwd(ctlIsWwd), .isHalt(ctlIsHalt), .isBranch(ctlIsBranch), .isJump(ctlIsJump),
        .isJumpReg(ctlIsJumpReg), .useRs(ctlUseRs), .useRt(ctlUseRt), .destReg(ctlDest)
    );

    registerFile i_regFile (
        .clk, .rstN, .rs(idRs), .rt(idRt), .rd(wbRd), .wData(wbData), .wEn(wbRegWrite),
        .rData1(idRsVal), .rData2(idRtVal)
    );

    hazardForwardUnit i_hazard (
        .idRs, .idRt, .idUseRs(ctlUseRs), .idUseRt(ctlUseRt),
        .idIsBranch(ctlIsBranch || ctlIsJumpReg), .exRd, .exRegWrite, .exMemRead,
        .memRd, .memRegWrite, .wbRd, .wbRegWrite, .exRs, .exRt, .stall, .forwardA, .forwardB
    );

    always_comb begin
        case (idOp)
            BEQ:     branchTaken = (idRsVal == idRtVal);
            BNE:     branchTaken = (idRsVal != idRtVal);
            BGZ:     branchTaken = !idRsVal[wordSize-1] && (idRsVal != '0);
            BLZ:     branchTaken = idRsVal[wordSize-1];
            default: branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = idPc1 + idImm;
    assign nextPc = ctlIsJumpReg ? idRsVal :
                    (ctlIsJump ? {idPc1[15:12], idInstr[11:0]} : branchTarget);
    assign redirect = !stall && ((ctlIsBranch && branchTaken) || ctlIsJump || ctlIsJumpReg);

    // EX operands
    assign opA = (forwardA == 2'b10) ? memResult : ((forwardA == 2'b01) ? wbData : exRsVal);
    assign opB = (forwardB == 2'b10) ? memResult : ((forwardB == 2'b01) ? wbData : exRtVal);

    aluUnit i_alu (.a(opA), .b(exAluSrcImm ? exImm : opB), .aluOp(exAluOp), .result(aluResult));

    assign exResult = exIsJump ? exPc1 : (exIsWwd ? opA : aluResult);  // link or WWD value

    assign dataAddr    = memResult[memAddrBits-1:0];
    assign dataWdata   = memStoreVal;
    assign dataRead    = memMemRead;
    assign dataWrite   = memMemWrite;
    assign wbData      = wbMemToReg ? wbLoadVal : wbResult;
    assign outputPort  = wbResult;
    assign outputValid = wbValid && wbIsWwd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
            {fetchOn, haltSeen, idValid, halted} <= 4'b0000;
            idInstr <= bubbleInstr;
            {exValid, exMemRead, exMemWrite, exRegWrite, exIsWwd, exIsHalt} <= 6'b000000;
            {memValid, memMemRead, memMemWrite, memRegWrite, memIsWwd, memIsHalt} <= 6'b000000;
            {wbValid, wbRegWrite, wbIsWwd, wbIsHalt} <= 4'b0000;
            numInst <= '0;
        end else if (!halted) begin
            fetchOn <= !haltSeen && !ctlIsHalt;  // nothing fetched past HLT
            if (ctlIsHalt) haltSeen <= 1'b1;
            if (!stall) begin
                if (redirect)     pc <= nextPc;
                else if (fetchOk) pc <= pcPlus1;
                idValid <= fetchOk && !redirect && !ctlIsHalt;
                idInstr <= (fetchOk && !redirect && !ctlIsHalt) ? fetchData : bubbleInstr;
            end
            exValid    <= idValid && !stall;
            exMemRead  <= ctlMemRead && !stall;
            exMemWrite <= ctlMemWrite && !stall;
            exRegWrite <= ctlRegWrite && !stall;
            exIsWwd    <= ctlIsWwd && !stall;
            exIsHalt   <= ctlIsHalt && !stall;
            {memValid, memMemRead, memMemWrite} <= {exValid, exMemRead, exMemWrite};
            {memRegWrite, memIsWwd, memIsHalt}  <= {exRegWrite, exIsWwd, exIsHalt};
            {wbValid, wbRegWrite, wbIsWwd, wbIsHalt} <= {memValid, memRegWrite, memIsWwd, memIsHalt};
            if (wbValid) numInst <= numInst + 1'b1;
            if (wbValid && wbIsHalt) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            if (!stall && fetchOk) idPc1 <= pcPlus1;
            {exAluOp, exAluSrcImm, exMemToReg, exIsJump} <=
                {ctlAluOp, ctlAluSrcImm, ctlMemToReg, ctlIsJump};
            {exRs, exRt, exRd} <= {idRs, idRt, ctlDest};
            {exRsVal, exRtVal, exImm, exPc1} <= {idRsVal, idRtVal, idImm, idPc1};
            {memRd, memMemToReg, memResult, memStoreVal} <= {exRd, exMemToReg, exResult, opB};
            {wbRd, wbMemToReg, wbResult, wbLoadVal} <= {memRd, memMemToReg, memResult, dataRdata};
        end
    end

endmodule

`default_nettype wire

/* src/memArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module memArbiter import cpuIsaPkg::*, cpuMemPkg::*; (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire  [memAddrBits-1:0] fetchAddr,
    input  wire                    fetchRead,
    input  wire  [memAddrBits-1:0] dataAddr,
    input  wire  [wordSize-1:0]    dataWdata,
    input  wire                    dataRead,
    input  wire                    dataWrite,
    output grantT                  grant,
    output logic [memAddrBits-1:0] memAddr,
    output logic [wordSize-1:0]    memWdata,
    output logic                   memRead,
    output logic                   memWrite
);

    grantT lastGrant;
    logic  dataReq;

    assign dataReq = dataRead || dataWrite;

    // data side always wins
    always_comb begin
        if (dataReq)        grant = grantData;
        else if (fetchRead) grant = grantFetch;
        else                grant = lastGrant;  // idle, park on previous owner
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) lastGrant <= grantFetch;
        else       lastGrant <= grant;
    end

    assign memAddr  = (grant == grantData) ? dataAddr : fetchAddr;
    assign memWdata = dataWdata;
    assign memRead  = (grant == grantData) ? dataRead : fetchRead;
    assign memWrite = (grant == grantData) && dataWrite;

endmodule

`default_nettype wire

/* src/cpuTop.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTop import cpuIsaPkg::*, cpuMemPkg::*; (
    input  wire                    clk,
    input  wire                    rstN,
    output logic [memAddrBits-1:0] memAddr,
    output logic [wordSize-1:0]    memWdata,
    output logic                   memRead,
    output logic                   memWrite,
    input  wire  [wordSize-1:0]    memRdata,
    output logic [wordSize-1:0]    outputPort,
    output logic                   outputValid,
    output logic [wordSize-1:0]    numInst,
    output logic                   halted
);

    grantT grant;
    logic [memAddrBits-1:0] fetchAddr, dataAddr;
    logic [wordSize-1:0] dataWdata;
    logic fetchRead, dataRead, dataWrite;

    // both ports see the shared read data
    cpuDatapath i_datapath (
        .clk, .rstN, .grant, .fetchAddr, .fetchRead, .fetchData(memRdata),
        .dataAddr, .dataWdata, .dataRead, .dataWrite, .dataRdata(memRdata),
        .outputPort, .outputValid, .numInst, .halted
    );

    memArbiter i_arbiter (
        .clk, .rstN, .fetchAddr, .fetchRead, .dataAddr, .dataWdata, .dataRead, .dataWrite,
        .grant, .memAddr, .memWdata, .memRead, .memWrite
    );

endmodule

`default_nettype wire

/* test/cpuTopTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuTopTb import cpuIsaPkg::*, cpuMemPkg::*; ();

    localparam int clkPeriod = 100;
    localparam logic [7:0] dataBase = 8'hc0;
    localparam logic [7:0] funcBase = 8'h70;  // JAL target

    logic clk, rstN;
    logic [memAddrBits-1:0] memAddr;
    logic [wordSize-1:0] memWdata, memRdata, outputPort, numInst;
    logic memRead, memWrite, outputValid, halted;

    logic [wordSize-1:0] mem [256];
    logic [wordSize-1:0] refMem [256];
    bit swdMark [256];  // words stored by the interpreter
    logic [wordSize-1:0] expWwd [$];
    logic [7:0] wp;
    integer seed;
    int stepCount, refRetired, valueErrors, otherErrors;

    cpuTop i_cpuTop (
        .clk, .rstN, .memAddr, .memWdata, .memRead, .memWrite, .memRdata,
        .outputPort, .outputValid, .numInst, .halted
    );

    // read data is only defined while a read is strobed
    assign memRdata = memRead ? mem[memAddr] : 'x;

    always @(posedge clk) begin
        if (memWrite) mem[memAddr] <= memWdata;
    end

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [wordSize-1:0] got,
                              input logic [wordSize-1:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
            valueErrors++;
        end
    endtask

    task automatic reportCounts();
        $display("%0d value errors, %0d other errors", valueErrors, otherErrors);
    endtask

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [15:0] encodeR(input logic [5:0] fn, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [1:0] rd);
        return {RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeI(input logic [3:0] op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [15:0] ins);
        mem[wp] = ins;
        wp = wp + 1'b1;
    endtask

    // instruction, then WWD of its destination
    task automatic emitShown(input logic [15:0] ins, input logic [1:0] dest);
        emit(ins);
        emit(encodeR(WWD, dest, 0, 0));
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [7:0] loopAt;
        for (int i = 0; i < 256; i++) mem[i] = {i[7:0], ~i[7:0]};
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            mem[dataBase + i] = r[15:0];
        end
        wp = 8'h00;
        emit(encodeI(ORI, 0, 3, dataBase));  // r3 is the data pointer
        emit(encodeI(LWD, 3, 1, 8'h00));
        emit(encodeI(ADI, 1, 1, randByte()));  // load-use
        emit(encodeI(LWD, 3, 0, 8'h01));
        emit(encodeR(WWD, 1, 0, 0));
        emitShown(encodeR(ADD, 0, 1, 2), 2);
        emitShown(encodeR(SUB, 2, 0, 2), 2);
        emitShown(encodeR(AND, 2, 1, 1), 1);
        emitShown(encodeR(ORR, 1, 2, 2), 2);
        emitShown(encodeR(NOT, 2, 0, 1), 1);
        emitShown(encodeR(TCP, 1, 0, 2), 2);
        emitShown(encodeR(SHL, 2, 0, 1), 1);
        emitShown(encodeR(SHR, 1, 0, 0), 0);
        emitShown(encodeI(LHI, 0, 1, randByte()), 1);
        emitShown(encodeI(ORI, 1, 1, randByte()), 1);
        emitShown(encodeI(ADI, 1, 2, randByte()), 2);
        emit(encodeI(SWD, 3, 2, 8'h02));
        emit(encodeI(SWD, 3, 0, 8'h03));
        emitShown(encodeI(LWD, 3, 1, 8'h02), 1);
        emit(encodeI(LWD, 3, 0, 8'h04));
        emit(encodeI(SWD, 3, 0, 8'h06));  // store data straight from a load
        // each branch jumps over exactly one WWD
        emitShown(encodeI(BEQ, 3, 3, 8'h01), 1);
        emitShown(encodeI(BNE, 3, 3, 8'h01), 3);
        emitShown(encodeI(BGZ, 3, 0, 8'h01), 1);
        emitShown(encodeI(BLZ, 3, 0, 8'h01), 3);
        emit(encodeR(TCP, 3, 0, 1));
        emitShown(encodeI(BLZ, 1, 0, 8'h01), 3);  // operand still in EX
        emitShown(encodeI(BGZ, 1, 0, 8'h01), 1);
        emitShown(encodeI(BNE, 1, 3, 8'h01), 0);
        emitShown(encodeI(BEQ, 1, 0, 8'h01), 0);
        emit(encodeI(LWD, 3, 0, 8'h05));
        emitShown(encodeI(BEQ, 0, 0, 8'h01), 1);  // waits for the load
        emitShown({JAL, 4'h0, funcBase}, 2);
        emitShown({JMP, 4'h0, wp + 8'd2}, 1);
        emit(encodeI(LHI, 0, 1, 8'h00));
        emit(encodeI(ORI, 1, 1, 8'h04));  // loop count
        loopAt = wp;
        emitShown(encodeI(ADI, 0, 0, randByte()), 0);
        emit(encodeI(ADI, 1, 1, 8'hff));
        emitShown(encodeI(BGZ, 1, 0, loopAt - wp - 8'd1), 1);
        emit(encodeI(SWD, 3, 0, 8'h07));
        emit(encodeR(HLT, 0, 0, 0));
        wp = funcBase;
        emitShown(encodeI(ADI, 0, 0, randByte()), 0);
        emit(encodeR(JPR, 2, 0, 0));
    endtask

    // ISA-level model over refMem
    function automatic int interpret();
        logic [wordSize-1:0] regs [4];
        logic [wordSize-1:0] pc, nextPc, ins, a, b, imm, sum;
        int steps;
        bit done;
        for (int i = 0; i < 4; i++) regs[i] = '0;
        pc = resetPc;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4000) begin
            ins = refMem[pc[memAddrBits-1:0]];
            a = regs[ins[11:10]];
            b = regs[ins[9:8]];
            imm = {{8{ins[7]}}, ins[7:0]};
            sum = a + imm;
            nextPc = pc + 1'b1;
            case (ins[15:12])
                ADI: regs[ins[9:8]] = sum;
                ORI: regs[ins[9:8]] = a | {8'h00, ins[7:0]};
                LHI: regs[ins[9:8]] = {ins[7:0], 8'h00};
                LWD: regs[ins[9:8]] = refMem[sum[memAddrBits-1:0]];
                SWD: begin
                    refMem[sum[memAddrBits-1:0]] = b;
                    swdMark[sum[memAddrBits-1:0]] = 1'b1;
                end
                BNE: if (a != b) nextPc = nextPc + imm;
                BEQ: if (a == b) nextPc = nextPc + imm;
                BGZ: if ($signed(a) > 0) nextPc = nextPc + imm;
                BLZ: if (a[15]) nextPc = nextPc + imm;
                JMP: nextPc = {nextPc[15:12], ins[11:0]};
                JAL: begin
                    regs[linkReg] = nextPc;
                    nextPc = {nextPc[15:12], ins[11:0]};
                end
                RTYPE: begin
                    case (ins[5:0])
                        ADD: regs[ins[7:6]] = a + b;
                        SUB: regs[ins[7:6]] = a - b;
                        AND: regs[ins[7:6]] = a & b;
                        ORR: regs[ins[7:6]] = a | b;
                        NOT: regs[ins[7:6]] = ~a;
                        TCP: regs[ins[7:6]] = -a;
                        SHL: regs[ins[7:6]] = a << 1;
                        SHR: regs[ins[7:6]] = {a[15], a[15:1]};
                        WWD: expWwd.push_back(a);
                        JPR: nextPc = a;
                        HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
            steps++;
            pc = nextPc;
        end
        refRetired = steps;
        return steps;
    endfunction

    always @(posedge clk) begin
        if (rstN) begin
            checkValue("memRead & memWrite", memRead & memWrite, 1'b0);
            if (outputValid) begin
                if (expWwd.size() == 0) begin
                    $display("outputValid pulsed with no WWD value left to expect");
                    otherErrors++;
                end else begin
                    checkValue("outputPort", outputPort, expWwd.pop_front());
                end
            end
        end
    end

    initial begin
        wait (stepCount > 0);
        #((stepCount * 4 + 40) * clkPeriod);
        $display("CPU never halted within %0d cycles", stepCount * 4 + 40);
        otherErrors++;
        reportCounts();
        $display("Test failed");
        $finish;
    end

    initial begin
        rstN = 1'b0;
        seed = 32'h9cd8bf89;
        valueErrors = 0;
        otherErrors = 0;
        buildProgram();
        for (int i = 0; i < 256; i++) refMem[i] = mem[i];
        stepCount = interpret();
        repeat (3) @(posedge clk);
        checkValue("outputValid", outputValid, 1'b0);
        checkValue("memRead", memRead, 1'b0);
        checkValue("memWrite", memWrite, 1'b0);
        checkValue("halted", halted, 1'b0);
        checkValue("numInst", numInst, 16'h0000);
        rstN <= 1'b1;
        while (!halted) @(posedge clk);
        for (int i = 0; i < 256; i++) begin
            if (swdMark[i]) checkValue($sformatf("mem[%02h]", i), mem[i], refMem[i]);
        end
        checkValue("numInst", numInst, refRetired);
        repeat (20) begin
            @(posedge clk);
            checkValue("halted", halted, 1'b1);
            checkValue("numInst", numInst, refRetired);
        end
        if (expWwd.size() != 0) begin
            $display("%0d expected WWD values never appeared on outputPort", expWwd.size());
            otherErrors++;
        end
        reportCounts();
        if (valueErrors + otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/cpuIsaPkg.sv
src/cpuMemPkg.sv
src/registerFile.sv
src/aluUnit.sv
src/controlDecoder.sv
src/hazardForwardUnit.sv
src/cpuDatapath.sv
src/memArbiter.sv
src/cpuTop.sv
test/cpuTopTb.sv

/* Bender.yml */
package:
  name: cpu16

sources:
  - files:
      - src/cpuIsaPkg.sv
      - src/cpuMemPkg.sv
      - src/registerFile.sv
      - src/aluUnit.sv
      - src/controlDecoder.sv
      - src/hazardForwardUnit.sv
      - src/cpuDatapath.sv
      - src/memArbiter.sv
      - src/cpuTop.sv
  - target: test
    files:
      - test/cpuTopTb.sv
